// ==== Bender.yml ====
package:
  name: mcast_router

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/noc_topo_pkg.sv
      - hdl/noc_flit_pkg.sv
      - hdl/route_xymask.sv
      - hdl/flit_fifo.sv
      - hdl/mcast_in_port.sv
      - hdl/out_port_arb.sv
      - hdl/mcast_router.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/mcast_router_assert.sv
      - verif/mcast_router_tb.sv

// ==== hdl/flit_fifo.sv ====
// Circular flit buffer with valid/ready on both sides
`timescale 1ns/1ps
`include "noc_macros.svh"

module flit_fifo (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                in_valid_i,
  output logic                in_ready_o,
  input  noc_flit_pkg::flit_t in_flit_i,
  output logic                out_valid_o,
  input  logic                out_ready_i,
  output noc_flit_pkg::flit_t out_flit_o
);

  localparam int unsigned Depth = `NOC_FIFO_DEPTH;
  localparam int unsigned PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW  = $clog2(Depth + 1);

  noc_flit_pkg::flit_t mem_q [Depth];
  logic [PtrW-1:0]     wr_ptr_q;
  logic [PtrW-1:0]     rd_ptr_q;
  logic [CntW-1:0]     count_q;
  logic                push;
  logic                pop;

  function automatic logic [PtrW-1:0] ptr_next(input logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign out_valid_o = (count_q != '0);
  assign in_ready_o  = (count_q != CntW'(Depth)) || out_ready_i; // Pass-through when full
  assign push        = in_valid_i && in_ready_o;
  assign pop         = out_valid_o && out_ready_i;
  assign out_flit_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= ptr_next(wr_ptr_q);
      if (pop)  rd_ptr_q <= ptr_next(rd_ptr_q);
      if (push && !pop) count_q <= count_q + 1'b1;
      else if (pop && !push) count_q <= count_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= in_flit_i;
  end

endmodule

// ==== hdl/mcast_in_port.sv ====
// Input port with flit FIFO, route computation and multicast fork
`timescale 1ns/1ps

module mcast_in_port (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  noc_topo_pkg::xy_id_t      xy_id_i,
  input  logic                      in_valid_i,
  output logic                      in_ready_o,
  input  noc_flit_pkg::flit_t       in_flit_i,
  output noc_topo_pkg::route_sel_t  req_o,
  input  noc_topo_pkg::route_sel_t  gnt_i,
  output noc_flit_pkg::flit_t       flit_o
);

  logic                      head_valid;
  logic                      head_pop;
  noc_flit_pkg::flit_t       head_flit;
  noc_topo_pkg::route_sel_t  route_sel;
  noc_topo_pkg::route_sel_t  served_q;   // Outputs that already took the head
  noc_topo_pkg::route_sel_t  remaining;

  flit_fifo u_fifo (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .in_flit_i   (in_flit_i),
    .out_valid_o (head_valid),
    .out_ready_i (head_pop),
    .out_flit_o  (head_flit)
  );

  route_xymask u_route (
    .flit_i      (head_flit),
    .xy_id_i     (xy_id_i),
    .route_sel_o (route_sel)
  );

  assign req_o     = head_valid ? (route_sel & ~served_q) : '0;
  assign remaining = route_sel & ~served_q & ~gnt_i;

  // Also drops a flit with an empty route set
  assign head_pop = head_valid && (remaining == '0);
  assign flit_o   = head_flit;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      served_q <= '0;
    end else if (head_pop) begin
      served_q <= '0;
    end else begin
      served_q <= served_q | gnt_i;
    end
  end

endmodule

// ==== hdl/mcast_router.sv ====
// Five-port multicast mesh router top level
`timescale 1ns/1ps

module mcast_router (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  noc_topo_pkg::xy_id_t  xy_id_i,
  input  logic                  in_valid_i  [noc_topo_pkg::NumDirs],
  output logic                  in_ready_o  [noc_topo_pkg::NumDirs],
  input  noc_flit_pkg::flit_t   in_flit_i   [noc_topo_pkg::NumDirs],
  output logic                  out_valid_o [noc_topo_pkg::NumDirs],
  input  logic                  out_ready_i [noc_topo_pkg::NumDirs],
  output noc_flit_pkg::flit_t   out_flit_o  [noc_topo_pkg::NumDirs]
);

  noc_topo_pkg::route_sel_t in_req   [noc_topo_pkg::NumDirs]; // Per input, bit per output
  noc_topo_pkg::route_sel_t in_gnt   [noc_topo_pkg::NumDirs];
  noc_topo_pkg::route_sel_t arb_req  [noc_topo_pkg::NumDirs]; // Per output, bit per input
  noc_topo_pkg::route_sel_t arb_gnt  [noc_topo_pkg::NumDirs];
  noc_flit_pkg::flit_t      head_flit [noc_topo_pkg::NumDirs];

  for (genvar i = 0; i < noc_topo_pkg::NumDirs; i++) begin : g_xpose
    for (genvar d = 0; d < noc_topo_pkg::NumDirs; d++) begin : g_bit
      assign arb_req[d][i] = in_req[i][d];
      assign in_gnt[i][d]  = arb_gnt[d][i];
    end
  end

  for (genvar i = 0; i < noc_topo_pkg::NumDirs; i++) begin : g_in
    mcast_in_port u_in_port (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .xy_id_i    (xy_id_i),
      .in_valid_i (in_valid_i[i]),
      .in_ready_o (in_ready_o[i]),
      .in_flit_i  (in_flit_i[i]),
      .req_o      (in_req[i]),
      .gnt_i      (in_gnt[i]),
      .flit_o     (head_flit[i])
    );
  end

  for (genvar d = 0; d < noc_topo_pkg::NumDirs; d++) begin : g_out
    out_port_arb u_out_arb (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .req_i       (arb_req[d]),
      .gnt_o       (arb_gnt[d]),
      .flit_i      (head_flit),
      .out_valid_o (out_valid_o[d]),
      .out_ready_i (out_ready_i[d]),
      .out_flit_o  (out_flit_o[d])
    );
  end

endmodule

// ==== hdl/noc_flit_pkg.sv ====
// Communication type, flit header and flit types
`include "noc_macros.svh"

package noc_flit_pkg;

  typedef enum logic [1:0] {
    Unicast   = 2'd0,
    Multicast = 2'd1,
    CollectB  = 2'd2 // Routed as unicast
  } commtype_e;

  typedef struct packed {
    noc_topo_pkg::xy_id_t src_id;
    noc_topo_pkg::xy_id_t dst_id;
    noc_topo_pkg::xy_id_t mask;   // Set bit means don't care
    commtype_e            commtype;
  } hdr_t;

  typedef struct packed {
    hdr_t                   hdr;
    logic [`NOC_DATA_W-1:0] data;
  } flit_t;

endpackage

// ==== hdl/noc_topo_pkg.sv ====
// Coordinate, node id, direction and route select types for the mesh
`include "noc_macros.svh"

package noc_topo_pkg;

  localparam int unsigned NumDirs = 5; // N, E, S, W, Eject

  typedef logic [`NOC_COORD_W-1:0] coord_t;

  // Node address, also used as a don't-care mask
  typedef struct packed {
    coord_t x;
    coord_t y;
  } xy_id_t;

  // Values index a route select vector
  typedef enum logic [2:0] {
    North = 3'd0,
    East  = 3'd1,
    South = 3'd2,
    West  = 3'd3,
    Eject = 3'd4
  } dir_e;

  typedef logic [NumDirs-1:0] route_sel_t; // One bit per dir_e

endpackage

// ==== hdl/out_port_arb.sv ====
// Round-robin output arbiter with one-entry output register
`timescale 1ns/1ps

module out_port_arb (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic [noc_topo_pkg::NumDirs-1:0]  req_i,
  output logic [noc_topo_pkg::NumDirs-1:0]  gnt_o,
  input  noc_flit_pkg::flit_t               flit_i [noc_topo_pkg::NumDirs],
  output logic                              out_valid_o,
  input  logic                              out_ready_i,
  output noc_flit_pkg::flit_t               out_flit_o
);

  localparam int unsigned IdxW = $clog2(noc_topo_pkg::NumDirs);

  logic [IdxW-1:0] rr_ptr_q;  // Highest priority input
  logic [IdxW-1:0] win_idx;
  logic            win_found;
  logic            load_ok;

  assign load_ok = !out_valid_o || out_ready_i;

  always_comb begin
    int idx;
    gnt_o     = '0;
    win_idx   = '0;
    win_found = 1'b0;
    for (int k = 0; k < noc_topo_pkg::NumDirs; k++) begin
      idx = (int'(rr_ptr_q) + k) % noc_topo_pkg::NumDirs;
      if (!win_found && req_i[idx]) begin
        win_found = 1'b1;
        win_idx   = IdxW'(idx);
      end
    end
    if (win_found && load_ok) gnt_o[win_idx] = 1'b1;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_valid_o <= 1'b0;
      rr_ptr_q    <= '0; // North first
    end else if (gnt_o != '0) begin
      out_valid_o <= 1'b1;
      rr_ptr_q    <= (win_idx == IdxW'(noc_topo_pkg::NumDirs - 1)) ? '0 : win_idx + 1'b1;
    end else if (out_ready_i) begin
      out_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt_o != '0) out_flit_o <= flit_i[win_idx];
  end

endmodule

// ==== hdl/route_xymask.sv ====
// XY route computation with destination mask for multicast
`timescale 1ns/1ps

module route_xymask (
  input  noc_flit_pkg::flit_t       flit_i,
  input  noc_topo_pkg::xy_id_t      xy_id_i,
  output noc_topo_pkg::route_sel_t  route_sel_o
);

  noc_topo_pkg::xy_id_t dst_id;
  noc_topo_pkg::xy_id_t src_id;
  noc_topo_pkg::xy_id_t mask;
  noc_topo_pkg::xy_id_t dst_max;
  noc_topo_pkg::xy_id_t dst_min;
  logic                 x_match;
  logic                 y_match;

  assign dst_id = flit_i.hdr.dst_id;
  assign src_id = flit_i.hdr.src_id;

  // CollectB ignores the mask
  assign mask = (flit_i.hdr.commtype == noc_flit_pkg::CollectB) ? '0 : flit_i.hdr.mask;

  // Corners of the addressed rectangle
  assign dst_max.x = dst_id.x | mask.x;
  assign dst_max.y = dst_id.y | mask.y;
  assign dst_min.x = dst_id.x & ~mask.x;
  assign dst_min.y = dst_id.y & ~mask.y;

  assign x_match = &(mask.x | ~(xy_id_i.x ^ dst_id.x));
  assign y_match = &(mask.y | ~(xy_id_i.y ^ dst_id.y));

  always_comb begin
    route_sel_o = '0;

    if (x_match && y_match) begin
      route_sel_o[noc_topo_pkg::Eject] = 1'b1;
    end

    // Spread along x only in the source row
    if (xy_id_i.y == src_id.y) begin
      if (xy_id_i.x >= src_id.x && xy_id_i.x < dst_max.x) begin
        route_sel_o[noc_topo_pkg::East] = 1'b1;
      end
      if (xy_id_i.x <= src_id.x && xy_id_i.x > dst_min.x) begin
        route_sel_o[noc_topo_pkg::West] = 1'b1;
      end
    end

    // Then along y in every matching column
    if (x_match) begin
      if (xy_id_i.y >= src_id.y && xy_id_i.y < dst_max.y) begin
        route_sel_o[noc_topo_pkg::North] = 1'b1;
      end
      if (xy_id_i.y <= src_id.y && xy_id_i.y > dst_min.y) begin
        route_sel_o[noc_topo_pkg::South] = 1'b1;
      end
    end
  end

endmodule

// ==== include/noc_macros.svh ====
// Coordinate width, input FIFO depth and payload width macros
`ifndef NOC_MACROS_SVH
`define NOC_MACROS_SVH

// Bits per x or y coordinate, 2 gives a 4x4 mesh
`define NOC_COORD_W 2

// Entries per input FIFO
`define NOC_FIFO_DEPTH 2

// Flit payload width
`define NOC_DATA_W 32

`endif

// ==== sources.f ====
+incdir+include
hdl/noc_topo_pkg.sv
hdl/noc_flit_pkg.sv
hdl/route_xymask.sv
hdl/flit_fifo.sv
hdl/mcast_in_port.sv
hdl/out_port_arb.sv
hdl/mcast_router.sv
verif/mcast_router_assert.sv
verif/mcast_router_tb.sv

// ==== verif/mcast_router_assert.sv ====
// Bound assertions on router output handshakes and reset behavior
`timescale 1ns/1ps

module mcast_router_assert (
  input logic                clk_i,
  input logic                rst_i,
  input logic                in_valid_i  [noc_topo_pkg::NumDirs],
  input logic                in_ready_o  [noc_topo_pkg::NumDirs],
  input logic                out_valid_o [noc_topo_pkg::NumDirs],
  input logic                out_ready_i [noc_topo_pkg::NumDirs],
  input noc_flit_pkg::flit_t out_flit_o  [noc_topo_pkg::NumDirs]
);

  logic [noc_topo_pkg::NumDirs-1:0] accept;
  logic                             seen_accept_q; // Some input took a flit
  int unsigned                      fail_cnt = 0;  // Failed assertion count

  always_comb begin
    for (int i = 0; i < noc_topo_pkg::NumDirs; i++) begin
      accept[i] = in_valid_i[i] && in_ready_o[i];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) seen_accept_q <= 1'b0;
    else if (accept != '0) seen_accept_q <= 1'b1;
  end

  for (genvar d = 0; d < noc_topo_pkg::NumDirs; d++) begin : g_dir
    a_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      out_valid_o[d] && !out_ready_i[d] |=> out_valid_o[d] && $stable(out_flit_o[d]))
      else begin
        fail_cnt++;
        $error("Output %0d dropped or changed a stalled flit", d);
      end
    a_reset: assert property (@(posedge clk_i) rst_i |=> !out_valid_o[d])
      else begin
        fail_cnt++;
        $error("Output %0d valid in the cycle after reset", d);
      end
    a_cause: assert property (@(posedge clk_i) disable iff (rst_i)
      $rose(out_valid_o[d]) |-> seen_accept_q)
      else begin
        fail_cnt++;
        $error("Output %0d valid before any input flit was accepted", d);
      end
  end

endmodule

bind mcast_router mcast_router_assert u_assert (.*);

// ==== verif/mcast_router_tb.sv ====
// Multicast router testbench with reference routing, scoreboard and watchdog
`timescale 1ns/1ps
`include "noc_macros.svh"

module mcast_router_tb;

  localparam int Period     = 100;
  localparam int NumPorts   = noc_topo_pkg::NumDirs;
  localparam int NumRandom  = 40; // Flits per input in the random phase
  localparam int TotalFlits = 12 + NumPorts * NumRandom;
  localparam int SampleDly  = 40; // Settled well before the next rising edge

  logic                 clk_i;
  logic                 rst_i;
  noc_topo_pkg::xy_id_t xy_id_i;
  logic                 in_valid_i  [NumPorts];
  logic                 in_ready_o  [NumPorts];
  noc_flit_pkg::flit_t  in_flit_i   [NumPorts];
  logic                 out_valid_o [NumPorts];
  logic                 out_ready_i [NumPorts];
  noc_flit_pkg::flit_t  out_flit_o  [NumPorts];

  noc_flit_pkg::flit_t exp_q [NumPorts*NumPorts][$]; // Input * 5 + output
  int                  pending;
  int                  seq_cnt [NumPorts];
  logic                rand_phase;

  mcast_router UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #(Period/2) clk_i = ~clk_i;
  end

  initial begin
    #((5 + 200 * TotalFlits) * Period);
    abort_run("Timeout while waiting for the router to deliver all flits");
  end

  initial begin
    wait (UUT.u_assert.fail_cnt != 0);
    abort_run("A bound router assertion failed");
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) abort_run($sformatf("** Error %s got %h exp %h", name, got, exp));
  endtask

  task automatic compare_dir(input string name, input noc_topo_pkg::dir_e got,
                             input noc_topo_pkg::dir_e exp);
    if (got !== exp) abort_run($sformatf("** Error %s got %h exp %h", name, got, exp));
  endtask

  task automatic compare_flit(input string name, input noc_flit_pkg::flit_t got,
                              input noc_flit_pkg::flit_t exp);
    if (got !== exp) abort_run($sformatf("** Error %s got %h exp %h", name, got, exp));
  endtask

  function automatic noc_topo_pkg::xy_id_t xy_coord(input int x, input int y);
    noc_topo_pkg::xy_id_t id;
    id.x = noc_topo_pkg::coord_t'(x);
    id.y = noc_topo_pkg::coord_t'(y);
    return id;
  endfunction

  // Route rule of one mesh node from the header fields
  function automatic noc_topo_pkg::route_sel_t expected_route(
    input noc_flit_pkg::hdr_t h, input noc_topo_pkg::xy_id_t me);
    noc_topo_pkg::xy_id_t     m;
    noc_topo_pkg::xy_id_t     hi;
    noc_topo_pkg::xy_id_t     lo;
    logic                     mx;
    logic                     my;
    noc_topo_pkg::route_sel_t sel;
    m  = (h.commtype == noc_flit_pkg::CollectB) ? '0 : h.mask;
    mx = 1'b1;
    my = 1'b1;
    for (int b = 0; b < `NOC_COORD_W; b++) begin
      if (!m.x[b] && me.x[b] != h.dst_id.x[b]) mx = 1'b0;
      if (!m.y[b] && me.y[b] != h.dst_id.y[b]) my = 1'b0;
    end
    hi  = h.dst_id | m; // Rectangle corners
    lo  = h.dst_id & ~m;
    sel = '0;
    sel[noc_topo_pkg::Eject] = mx && my;
    if (me.y == h.src_id.y) begin
      sel[noc_topo_pkg::East] = (me.x >= h.src_id.x) && (me.x < hi.x);
      sel[noc_topo_pkg::West] = (me.x <= h.src_id.x) && (me.x > lo.x);
    end
    if (mx) begin
      sel[noc_topo_pkg::North] = (me.y >= h.src_id.y) && (me.y < hi.y);
      sel[noc_topo_pkg::South] = (me.y <= h.src_id.y) && (me.y > lo.y);
    end
    return sel;
  endfunction

  function automatic noc_topo_pkg::dir_e first_dir(input noc_topo_pkg::route_sel_t sel);
    noc_topo_pkg::dir_e dir;
    dir = noc_topo_pkg::North;
    for (int d = NumPorts - 1; d >= 0; d--) begin
      if (sel[d]) dir = noc_topo_pkg::dir_e'(3'(d));
    end
    return dir;
  endfunction

  function automatic noc_flit_pkg::flit_t make_flit(input int port,
    input noc_topo_pkg::xy_id_t src, input noc_topo_pkg::xy_id_t dst,
    input noc_topo_pkg::xy_id_t mask, input noc_flit_pkg::commtype_e ct);
    noc_flit_pkg::flit_t f;
    f.hdr.src_id   = src;
    f.hdr.dst_id   = dst;
    f.hdr.mask     = mask;
    f.hdr.commtype = ct;
    f.data         = {4'(port), 12'(seq_cnt[port]), 16'($urandom)}; // Input tag on top
    seq_cnt[port]++;
    return f;
  endfunction

  task automatic send_flit(input int port, input noc_flit_pkg::flit_t f);
    noc_topo_pkg::route_sel_t sel;
    @(negedge clk_i);
    in_valid_i[port] = 1'b1;
    in_flit_i[port]  = f;
    #SampleDly;
    while (!in_ready_o[port]) begin
      @(negedge clk_i);
      #SampleDly;
    end
    sel = expected_route(f.hdr, xy_id_i);
    for (int d = 0; d < NumPorts; d++) begin
      if (sel[d]) begin
        exp_q[port*NumPorts+d].push_back(f);
        pending++;
      end
    end
  endtask

  task automatic idle_port(input int port);
    @(negedge clk_i);
    in_valid_i[port] = 1'b0;
  endtask

  task automatic wait_drain();
    while (pending != 0) @(negedge clk_i);
    repeat (3) @(negedge clk_i); // Room for a stray copy
  endtask

  task automatic send_and_drain(input int port, input noc_topo_pkg::xy_id_t src,
    input noc_topo_pkg::xy_id_t dst, input noc_topo_pkg::xy_id_t mask,
    input noc_flit_pkg::commtype_e ct);
    send_flit(port, make_flit(port, src, dst, mask, ct));
    idle_port(port);
    wait_drain();
  endtask

  task automatic send_random(input int port);
    noc_topo_pkg::xy_id_t    mask;
    noc_flit_pkg::commtype_e ct;
    repeat (NumRandom) begin
      mask = ($urandom_range(1) == 0) ? '0 : xy_coord($urandom_range(3), $urandom_range(3));
      ct   = noc_flit_pkg::commtype_e'(2'($urandom_range(2)));
      send_flit(port, make_flit(port, xy_coord($urandom_range(3), $urandom_range(3)),
                                xy_coord($urandom_range(3), $urandom_range(3)), mask, ct));
      if ($urandom_range(3) == 0) idle_port(port);
    end
    idle_port(port);
  endtask

  initial begin
    forever begin
      @(negedge clk_i);
      for (int d = 0; d < NumPorts; d++) begin
        out_ready_i[d] = rand_phase ? ($urandom_range(3) != 0) : 1'b1;
      end
    end
  end

  // Scoreboard looks once per cycle before the rising edge
  initial begin
    noc_flit_pkg::flit_t      got;
    noc_flit_pkg::flit_t      exp;
    noc_topo_pkg::route_sel_t sel;
    int                       tag;
    forever begin
      @(negedge clk_i);
      #SampleDly;
      for (int d = 0; d < NumPorts; d++) begin
        if (out_valid_o[d] && out_ready_i[d]) begin
          got = out_flit_o[d];
          tag = int'(got.data[31:28]);
          if (tag >= NumPorts) abort_run("Output flit carries an unknown input tag");
          sel = expected_route(got.hdr, xy_id_i);
          if (sel == '0) abort_run("A flit with an empty route set left the router");
          compare_dir($sformatf("out_dir from input %0d", tag), noc_topo_pkg::dir_e'(3'(d)),
                      sel[d] ? noc_topo_pkg::dir_e'(3'(d)) : first_dir(sel));
          if (exp_q[tag*NumPorts+d].size() == 0) begin
            abort_run($sformatf("Extra copy from input %0d on output %0d", tag, d));
          end
          exp = exp_q[tag*NumPorts+d].pop_front();
          pending--;
          compare_flit($sformatf("out_flit_o[%0d]", d), got, exp);
        end
      end
    end
  end

  initial begin
    void'($urandom(32'hd872f2d8));
    rst_i      = 1'b1;
    xy_id_i    = xy_coord(1, 2);
    pending    = 0;
    rand_phase = 1'b0;
    for (int p = 0; p < NumPorts; p++) begin
      in_valid_i[p]  = 1'b0;
      in_flit_i[p]   = '0;
      out_ready_i[p] = 1'b1;
      seq_cnt[p]     = 0;
    end
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    for (int d = 0; d < NumPorts; d++) begin
      compare_bit($sformatf("out_valid_o[%0d]", d), out_valid_o[d], 1'b0);
    end

    send_and_drain(0, xy_coord(1, 2), xy_coord(1, 2), xy_coord(0, 0), noc_flit_pkg::Unicast);
    send_and_drain(1, xy_coord(1, 2), xy_coord(3, 2), xy_coord(0, 0), noc_flit_pkg::Unicast);
    send_and_drain(2, xy_coord(1, 2), xy_coord(0, 2), xy_coord(0, 0), noc_flit_pkg::Unicast);
    send_and_drain(3, xy_coord(1, 0), xy_coord(1, 3), xy_coord(0, 0), noc_flit_pkg::Unicast);
    send_and_drain(4, xy_coord(1, 3), xy_coord(1, 0), xy_coord(0, 0), noc_flit_pkg::Unicast);
    send_and_drain(0, xy_coord(0, 2), xy_coord(2, 1), xy_coord(0, 0), noc_flit_pkg::Unicast);
    send_and_drain(1, xy_coord(1, 2), xy_coord(0, 0), xy_coord(3, 3), noc_flit_pkg::Multicast);
    send_and_drain(2, xy_coord(1, 2), xy_coord(0, 1), xy_coord(1, 1), noc_flit_pkg::Multicast);
    send_and_drain(3, xy_coord(1, 2), xy_coord(1, 2), xy_coord(3, 3), noc_flit_pkg::CollectB);
    send_and_drain(4, xy_coord(1, 2), xy_coord(0, 0), xy_coord(3, 3), noc_flit_pkg::CollectB);

    // Empty route set followed by a normal flit
    send_flit(0, make_flit(0, xy_coord(0, 0), xy_coord(3, 3), xy_coord(0, 0),
                           noc_flit_pkg::Unicast));
    send_flit(0, make_flit(0, xy_coord(1, 2), xy_coord(1, 2), xy_coord(0, 0),
                           noc_flit_pkg::Unicast));
    idle_port(0);
    wait_drain();

    rand_phase = 1'b1;
    for (int p = 0; p < NumPorts; p++) begin
      fork
        automatic int port = p;
        send_random(port);
      join_none
    end
    wait fork;
    rand_phase = 1'b0;
    wait_drain();

    if (pending == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      abort_run($sformatf("%0d expected copies never arrived", pending));
    end
  end

endmodule
